//--- rtl/discrete_pkg.sv
/*
 * Shared constants and the sample bus type of the discrete tone board.
 * Modules pull these in with a wildcard import of discrete_pkg.
 * Oscillator wave lengths are derived here from the R and C values.
 */
package discrete_pkg;

    ////////////////////////////////////////
    // clocking
    ////////////////////////////////////////
    localparam int clock_rate   = 50_000_000;               // system clock, Hz
    localparam int sample_rate  = 48_000;                   // audio rate, Hz
    localparam int sample_div   = clock_rate / sample_rate; // 1041 clocks per sample
    localparam int sample_div_w = $clog2(sample_div);       // divider counter width

    ////////////////////////////////////////
    // RC invertor ring components
    ////////////////////////////////////////
    localparam longint osc_a_r_ohm = 4300;   // R1 of voice A
    localparam longint osc_b_r_ohm = 2200;   // R1 of voice B
    localparam longint osc_c_uf_16 = 655;    // 0.01 uF << 16, shared cap value

    localparam longint k_ohm_scale_24 = 16777; // 1/1000 << 24
    localparam longint half_ratio_16  = 14895; // 1/2.2/2 << 16

    // f = 1 / (2.2 R C) / 2, kept in 16 bit fixed point throughout
    // R in kohm times C in uF gives RC in ms, hence the factor 1000 below
    function automatic int calc_wave_len(longint r_ohm);
        longint r_k_ohm_16;
        longint rc_ms_16;
        longint freq_hz_16;
        r_k_ohm_16 = (r_ohm * k_ohm_scale_24) >>> 8;          // R in kohm << 16
        rc_ms_16   = (r_k_ohm_16 * osc_c_uf_16) >>> 16;       // RC in ms << 16
        freq_hz_16 = ((half_ratio_16 * 1000) <<< 16) / rc_ms_16; // Hz << 16
        return int'((longint'(clock_rate) <<< 16) / freq_hz_16);
    endfunction

    localparam int osc_a_wave_len = calc_wave_len(osc_a_r_ohm); // about 9450 clocks
    localparam int osc_b_wave_len = calc_wave_len(osc_b_r_ohm); // about 4830 clocks

    ////////////////////////////////////////
    // levels and filter
    ////////////////////////////////////////
    localparam logic signed [15:0] osc_high_level = 16'sd16384; // square wave high level
    localparam int filter_shift = 3;                            // low-pass coefficient 1/8

    // sample bus between all stages, strobe rides along with the data
    typedef struct packed {
        logic               strobe; // one cycle, data valid
        logic signed [15:0] data;   // signed audio sample
    } audio_sample_t;

endpackage

//--- rtl/sample_rate_divider.sv
/*
 * Divides the system clock down to the audio rate.
 * Emits a single-cycle strobe once every sample_div clocks.
 */
`timescale 1ns/1ps

module sample_rate_divider
    import discrete_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic sample_strobe
);

    logic [sample_div_w-1:0] div_count; // position inside one sample period

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_count     <= '0;
            sample_strobe <= 1'b0;
        end else if (div_count == sample_div_w'(sample_div - 1)) begin
            div_count     <= '0;    // wrap, one sample period done
            sample_strobe <= 1'b1;
        end else begin
            div_count     <= div_count + 1'b1;
            sample_strobe <= 1'b0;
        end
    end

    // sample_div is far above 1, so the strobe must always drop again
    a_strobe_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_strobe |=> !sample_strobe
    );

endmodule

//--- rtl/invertor_square_osc.sv
/*
 * Square-wave model of an RC ring of two invertors.
 * A free-running counter spans one wave of wave_len clocks; the level
 * is high in the first half and is sampled onto each sample strobe.
 */
`timescale 1ns/1ps

module invertor_square_osc
    import discrete_pkg::*;
#(
    parameter int wave_len = 9452   // full wave in clock cycles
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          enable,
    input  logic          sample_strobe,
    output audio_sample_t voice
);

    localparam int count_w = $clog2(wave_len);

    logic [count_w-1:0] wave_count; // phase inside the wave
    logic               level_high;  // first half of the wave

    ////////////////////////////////////////
    // wave counter
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n || !enable) begin
            wave_count <= '0;  // disabled voice sits at phase 0
        end else if (wave_count == count_w'(wave_len - 1)) begin
            wave_count <= '0;  // period is exactly wave_len
        end else begin
            wave_count <= wave_count + 1'b1;
        end
    end

    assign level_high = enable && (wave_count < count_w'(wave_len / 2));

    ////////////////////////////////////////
    // sampled output
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            voice <= '0;
        end else begin
            voice.strobe <= sample_strobe; // strobe moves on one stage
            if (sample_strobe) begin
                voice.data <= level_high ? osc_high_level : 16'sd0;
            end
        end
    end

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(wave_count) < wave_len
    );

endmodule

//--- rtl/rc_lowpass_filter.sv
/*
 * First-order low-pass standing in for the RC stage after voice A.
 * On each strobe the state moves toward the input by (x - y) >>> filter_shift.
 */
`timescale 1ns/1ps

module rc_lowpass_filter
    import discrete_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  audio_sample_t voice_in,
    output audio_sample_t voice_out
);

    logic signed [15:0] state;    // filter output y
    logic               strobe_q; // strobe delayed by one stage
    logic signed [16:0] diff;     // x - y, one guard bit
    logic signed [16:0] step;     // shifted difference
    logic signed [16:0] y_next;

    // arithmetic shift floors, so a falling edge settles at exactly 0
    assign diff   = {voice_in.data[15], voice_in.data} - {state[15], state};
    assign step   = diff >>> filter_shift;
    assign y_next = {state[15], state} + step;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= voice_in.strobe;
            if (voice_in.strobe) begin
                state <= y_next[15:0]; // stays within the input range
            end
        end
    end

    assign voice_out.strobe = strobe_q;
    assign voice_out.data   = state;

    // the input only ever swings between 0 and the oscillator high level
    a_output_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state >= 0) && (state <= osc_high_level)
    );

endmodule

//--- rtl/voice_mixer.sv
/*
 * Adds filtered voice A and raw voice B with signed 16 bit saturation.
 * Voice B is held one register so both voices line up on voice A's strobe.
 */
`timescale 1ns/1ps

module voice_mixer
    import discrete_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  audio_sample_t voice_a,
    input  audio_sample_t voice_b,
    output audio_sample_t mix
);

    logic signed [15:0] b_data_q; // voice B, one stage late
    logic signed [16:0] sum;      // full width sum
    logic signed [15:0] sum_sat;

    ////////////////////////////////////////
    // alignment and sum
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_data_q <= '0;
        end else if (voice_b.strobe) begin
            b_data_q <= voice_b.data;
        end
    end

    assign sum = {voice_a.data[15], voice_a.data} + {b_data_q[15], b_data_q};

    // top two bits differ only on overflow, sign bit picks the rail
    always_comb begin
        if (sum[16] != sum[15]) begin
            sum_sat = sum[16] ? 16'sh8000 : 16'sh7fff;
        end else begin
            sum_sat = sum[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mix <= '0;
        end else begin
            mix.strobe <= voice_a.strobe;
            if (voice_a.strobe) begin
                mix.data <= sum_sat;
            end
        end
    end

    // voice A has one more stage upstream than voice B
    a_voices_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        voice_a.strobe |-> $past(voice_b.strobe)
    );

endmodule

//--- rtl/discrete_tone_board.sv
/*
 * Top of the discrete tone board.
 * Divider, two invertor oscillators, low-pass on voice A and the mixer.
 * audio.strobe follows sample_strobe by three clocks.
 */
`timescale 1ns/1ps

module discrete_tone_board
    import discrete_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic [1:0]    voice_enable, // bit 0 voice A, bit 1 voice B
    output logic          sample_strobe,
    output audio_sample_t audio
);

    audio_sample_t voice_a_raw;  // oscillator A, one clock after strobe
    audio_sample_t voice_b_raw;  // oscillator B, one clock after strobe
    audio_sample_t voice_a_filt; // filtered A, two clocks after strobe

    ////////////////////////////////////////
    // sample clock
    ////////////////////////////////////////
    sample_rate_divider i_sample_rate_divider (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe)
    );

    ////////////////////////////////////////
    // voices
    ////////////////////////////////////////
    invertor_square_osc #(.wave_len(osc_a_wave_len)) i_osc_a (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (voice_enable[0]),
        .sample_strobe (sample_strobe),
        .voice         (voice_a_raw)
    );

    invertor_square_osc #(.wave_len(osc_b_wave_len)) i_osc_b (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (voice_enable[1]),
        .sample_strobe (sample_strobe),
        .voice         (voice_b_raw)
    );

    rc_lowpass_filter i_rc_lowpass_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .voice_in  (voice_a_raw),
        .voice_out (voice_a_filt)
    );

    voice_mixer i_voice_mixer (
        .clk     (clk),
        .rst_n   (rst_n),
        .voice_a (voice_a_filt),
        .voice_b (voice_b_raw), // delayed inside the mixer
        .mix     (audio)
    );

endmodule

//--- verif/tone_board_checker.sv
/*
 * Cycle model of the tone board and the comparison against the DUT.
 * The model advances on each rising edge from the enables and the reset;
 * DUT outputs are compared on the falling edge, once they have settled.
 */
`timescale 1ns/1ps

module tone_board_checker
    import discrete_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input logic [1:0]    voice_enable,
    input logic          sample_strobe,
    input audio_sample_t audio
);

    string test_name   = "none"; // current test, set from the testbench
    int    error_count = 0;      // mismatches seen so far
    bit    armed       = 1'b0;   // set once a reset edge has been seen

    int edge_count = 0;          // rising edges since time zero
    int div_count;               // model of the sample divider
    bit exp_sample_strobe;
    int count_a;                 // wave phase of voice A
    int count_b;                 // wave phase of voice B
    int filt_y;                  // low-pass state of voice A
    bit exp_audio_strobe;
    int exp_audio_data;
    int due_q[$];                // edge at which a mixed sample shows up
    int value_q[$];              // the mixed sample itself

    ////////////////////////////////////////
    // model rules
    ////////////////////////////////////////
    function automatic int saturate16(int value);
        if (value > 32767) begin
            return 32767;
        end
        if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    // first half of the wave is high, a disabled voice is silent
    function automatic int square_level(bit en, int count, int wave_len);
        if (en && (count < wave_len / 2)) begin
            return int'(osc_high_level);
        end
        return 0;
    endfunction

    function automatic int next_count(bit en, int count, int wave_len);
        if (!en || (count == wave_len - 1)) begin
            return 0; // held in phase 0, or one wave done
        end
        return count + 1;
    endfunction

    task automatic report_mismatch(input string what, input logic signed [31:0] expected,
                                   input logic signed [31:0] actual);
        error_count++;
        $display("FAILED %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    endtask

    ////////////////////////////////////////
    // model step, one per rising edge
    ////////////////////////////////////////
    always @(posedge clk) begin
        int level_a;
        int level_b;
        edge_count++;
        if (!rst_n) begin
            armed             = 1'b1;
            div_count         = 0;
            exp_sample_strobe = 1'b0;
            count_a           = 0;
            count_b           = 0;
            filt_y            = 0;
            exp_audio_strobe  = 1'b0;
            exp_audio_data    = 0;
            due_q.delete();   // samples in flight are lost
            value_q.delete();
        end else begin
            exp_audio_strobe = 1'b0;
            if ((due_q.size() > 0) && (due_q[0] == edge_count)) begin
                void'(due_q.pop_front());
                exp_audio_data   = value_q.pop_front();
                exp_audio_strobe = 1'b1;
            end
            // strobe seen at this edge reaches audio two edges later
            if (exp_sample_strobe) begin
                level_a = square_level(voice_enable[0], count_a, osc_a_wave_len);
                level_b = square_level(voice_enable[1], count_b, osc_b_wave_len);
                filt_y  = filt_y + ((level_a - filt_y) >>> filter_shift);
                due_q.push_back(edge_count + 2);
                value_q.push_back(saturate16(filt_y + level_b));
            end
            count_a = next_count(voice_enable[0], count_a, osc_a_wave_len);
            count_b = next_count(voice_enable[1], count_b, osc_b_wave_len);
            if (div_count == sample_div - 1) begin
                div_count         = 0;
                exp_sample_strobe = 1'b1;
            end else begin
                div_count         = div_count + 1;
                exp_sample_strobe = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // comparison
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (armed) begin
            if (sample_strobe !== exp_sample_strobe) begin
                report_mismatch("sample_strobe", 32'(exp_sample_strobe), 32'(sample_strobe));
            end
            if (audio.strobe !== exp_audio_strobe) begin
                report_mismatch("audio.strobe", 32'(exp_audio_strobe), 32'(audio.strobe));
            end
            if (audio.data !== 16'(exp_audio_data)) begin
                report_mismatch("audio.data", exp_audio_data, audio.data);
            end
        end
    end

endmodule

//--- verif/tb_discrete_tone_board.sv
/*
 * Testbench for the discrete tone board.
 * Drives clock, reset and LFSR-chosen voice enables through six tests,
 * while tone_board_checker compares every output with its cycle model.
 */
`timescale 1ns/1ps

module tb_discrete_tone_board
    import discrete_pkg::*;
();

    localparam int          drive_delay    = 1;               // ns after the rising edge
    localparam int          reset_cycles   = 16;
    localparam int          strobe_timeout = sample_div + 16; // cycles allowed per wait
    localparam logic [15:0] lfsr_seed      = 16'd53;

    logic          clk;
    logic          rst_n;
    logic [1:0]    voice_enable;
    logic          sample_strobe;
    audio_sample_t audio;

    logic [15:0] lfsr_state;
    string       test_name;
    int          tb_errors;
    int          tests_run;
    int          tests_failed;
    int          errs_at_start;
    event        abort_event;
    string       abort_reason;

    initial clk = 1'b0;
    always #4 clk = ~clk; // 8 ns period

    discrete_tone_board i_discrete_tone_board (
        .clk           (clk),
        .rst_n         (rst_n),
        .voice_enable  (voice_enable),
        .sample_strobe (sample_strobe),
        .audio         (audio)
    );

    tone_board_checker i_tone_board_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .voice_enable  (voice_enable),
        .sample_strobe (sample_strobe),
        .audio         (audio)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    // galois LFSR over x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic int draw_bits(input int n);
        int i;
        int value;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic int samples_for_waves(input int waves, input int wave_len);
        return (waves * wave_len) / sample_div;
    endfunction

    task automatic drive_enable(input logic [1:0] en);
        @(posedge clk);
        #drive_delay;
        voice_enable = en;
    endtask

    task automatic abort_run(input string reason);
        abort_reason = reason;
        -> abort_event;
    endtask

    task automatic check_equal(input string what, input int expected, input int actual);
        if (expected != actual) begin
            tb_errors++;
            $display("FAILED %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic check_in_range(input int low, input int high, input int actual);
        if ((actual < low) || (actual > high)) begin
            tb_errors++;
            $display("FAILED %s: audio.data expected %0d to %0d actual %0d",
                     test_name, low, high, actual);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        if (!cond) begin
            tb_errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    // counts rising edges until sample_strobe is seen high at a falling edge
    task automatic wait_sample_strobe(output int cycles);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (sample_strobe) begin
                done = 1'b1;
            end else if (n > strobe_timeout) begin
                abort_run("no sample_strobe came within the timeout");
            end
        end
        cycles = n;
    endtask

    task automatic wait_audio_strobe(output int cycles);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (audio.strobe) begin
                done = 1'b1;
            end else if (n > strobe_timeout) begin
                abort_run("no audio.strobe came within the timeout");
            end
        end
        cycles = n;
    endtask

    task automatic begin_test(input string name);
        test_name                        = name;
        i_tone_board_checker.test_name   = name;
        errs_at_start = tb_errors + i_tone_board_checker.error_count;
    endtask

    task automatic end_test();
        int errs;
        errs = tb_errors + i_tone_board_checker.error_count - errs_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAILED %s: %0d checks went wrong", test_name, errs);
        end
    endtask

    // a wait that ran out of time ends the whole run here
    initial begin
        @(abort_event);
        $display("%s: %s", test_name, abort_reason);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        int cycles;
        int delay;
        int level;
        int prev;
        int highs;
        int lows;
        int rises;
        int falls;
        int overlaps;
        int waves;
        logic [1:0] en;
        logic [1:0] prev_en;
        rst_n        = 1'b0;
        voice_enable = 2'b00;
        lfsr_state   = lfsr_seed;
        tb_errors    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        // divider cadence and pipeline latency
        begin_test("strobe_cadence");
        wait_sample_strobe(cycles);
        check_equal("cycles to first sample_strobe", sample_div, cycles);
        repeat (3) begin
            wait_audio_strobe(delay);
            check_equal("audio.strobe delay", 3, delay);
            wait_sample_strobe(cycles);
            check_equal("sample_strobe period", sample_div, delay + cycles);
        end
        end_test();

        // voice B alone gives plain square levels
        begin_test("voice_b_only");
        drive_enable(2'b10);
        wait_audio_strobe(cycles);  // sample in flight
        highs = 0;
        lows  = 0;
        repeat (samples_for_waves(3, osc_b_wave_len)) begin
            wait_audio_strobe(cycles);
            level = int'(audio.data);
            if (level == int'(osc_high_level)) begin
                highs++;
            end else if (level == 0) begin
                lows++;
            end else begin
                tb_errors++;
                $display("FAILED %s: audio.data expected 0 or %0d actual %0d",
                         test_name, osc_high_level, level);
            end
        end
        check_true(highs > 0, "voice B never reached its high level");
        check_true(lows > 0, "voice B never dropped to zero");
        end_test();

        // voice A alone through the low-pass
        begin_test("voice_a_only");
        drive_enable(2'b01);
        repeat (2) wait_audio_strobe(cycles); // flush old voice B
        prev  = int'(audio.data);
        rises = 0;
        falls = 0;
        repeat (samples_for_waves(4, osc_a_wave_len)) begin
            wait_audio_strobe(cycles);
            level = int'(audio.data);
            check_in_range(0, int'(osc_high_level), level);
            if (level > prev) begin
                rises++;
            end else if (level < prev) begin
                falls++;
            end
            prev = level;
        end
        check_true(rises > 0, "filtered voice A never rose");
        check_true(falls > 0, "filtered voice A never fell");
        end_test();

        // both voices summed with saturation
        begin_test("both_voices");
        drive_enable(2'b11);
        repeat (2) wait_audio_strobe(cycles);
        overlaps = 0;
        repeat (samples_for_waves(4, osc_a_wave_len)) begin
            wait_audio_strobe(cycles);
            level = int'(audio.data);
            check_in_range(0, 32767, level);
            if (level > int'(osc_high_level)) begin
                overlaps++;
            end
        end
        check_true(overlaps > 0, "the two voices never added above one voice level");
        end_test();

        // random enables held for whole waves of voice B
        begin_test("random_toggles");
        prev_en = 2'b11;
        repeat (12) begin
            en    = 2'(draw_bits(2));
            waves = 1 + draw_bits(2);
            drive_enable(en);
            @(posedge clk);
            @(negedge clk);
            if (prev_en[0] && !en[0]) begin
                check_equal("voice A phase after enable drop", 0,
                            int'(i_discrete_tone_board.i_osc_a.wave_count));
            end
            if (prev_en[1] && !en[1]) begin
                check_equal("voice B phase after enable drop", 0,
                            int'(i_discrete_tone_board.i_osc_b.wave_count));
            end
            repeat (waves * osc_b_wave_len) @(posedge clk);
            prev_en = en;
        end
        end_test();

        // reset with a sample in flight and a clean restart after it
        begin_test("reset_mid_run");
        drive_enable(2'b11);
        repeat (5) wait_audio_strobe(cycles);
        wait_sample_strobe(cycles);
        @(posedge clk);
        #drive_delay;
        rst_n = 1'b0;
        repeat (reset_cycles) begin
            @(posedge clk);
            @(negedge clk);
            check_equal("sample_strobe in reset", 0, int'(sample_strobe));
            check_equal("audio.strobe in reset", 0, int'(audio.strobe));
            check_equal("audio.data in reset", 0, int'(audio.data));
        end
        @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        wait_sample_strobe(cycles);
        check_equal("cycles to first sample_strobe", sample_div, cycles);
        repeat (samples_for_waves(3, osc_a_wave_len)) wait_audio_strobe(cycles);
        end_test();

        $display("tests %0d, passed %0d, failed %0d, mismatches %0d", tests_run,
                 tests_run - tests_failed, tests_failed,
                 tb_errors + i_tone_board_checker.error_count);
        if ((tests_failed == 0) && (tb_errors + i_tone_board_checker.error_count == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/discrete_pkg.sv
rtl/sample_rate_divider.sv
rtl/invertor_square_osc.sv
rtl/rc_lowpass_filter.sv
rtl/voice_mixer.sv
rtl/discrete_tone_board.sv
verif/tone_board_checker.sv
verif/tb_discrete_tone_board.sv

//--- run_sim.sh
#!/bin/sh
# Build the tone board testbench with Verilator and run it.
# The run counts as passed only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_discrete_tone_board \
    --Mdir obj_dir -o tb_discrete_tone_board \
    -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_discrete_tone_board)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi
